// File: source/soc_mem_pkg.sv
package soc_mem_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus types
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  //////////////////////////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////////////////////////

  // RAM hit when the bits outside the mask equal the base
  localparam addr_t RAM_BASE_ADDR = 32'h4000_0000;
  localparam addr_t RAM_MASK_ADDR = 32'h000f_ffff;

  // 64-bit cycle timer, two word addresses
  localparam addr_t TIMER_LO_ADDR = 32'h3000_0000;
  localparam addr_t TIMER_HI_ADDR = 32'h3000_0004;

  //////////////////////////////////////////////////////////////////////
  // Program loader
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE,
    COUNT_LO,
    COUNT_HI,
    DATA,
    DONE
  } loader_state_e;

  // First byte of a load stream
  typedef enum logic [7:0] {
    OP_LOAD = 8'hA5
  } loader_op_e;

endpackage

// File: source/byte_ram.sv
module byte_ram #(
  parameter int RAM_DEPTH = 1024
) (
  input  logic                         clk_i,
  input  soc_mem_pkg::strb_t           we_i,
  input  logic                         re_i,
  input  logic [$clog2(RAM_DEPTH)-1:0] addr_i,
  input  soc_mem_pkg::data_t           wdata_i,
  output soc_mem_pkg::data_t           rdata_o
);

  soc_mem_pkg::data_t mem [RAM_DEPTH];

  // Power-up contents are all zero
  initial begin
    for (int i = 0; i < RAM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Byte-lane writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < 4; b++) begin
      if (we_i[b]) begin
        mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registered read
  //////////////////////////////////////////////////////////////////////

  // Output holds its last value between reads
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

// File: source/uart_rx.sv
module uart_rx #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic       clk_i,
  input  logic       rst_n,
  input  logic       rx_i,
  output logic [7:0] byte_o,
  output logic       valid_o
);

  localparam int CW = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CW-1:0] HALF_BIT = CW'(CLKS_PER_BIT / 2 - 1);
  localparam logic [CW-1:0] FULL_BIT = CW'(CLKS_PER_BIT - 1);

  // Receiver phases
  localparam logic [1:0] PH_IDLE  = 2'd0;
  localparam logic [1:0] PH_START = 2'd1;
  localparam logic [1:0] PH_DATA  = 2'd2;
  localparam logic [1:0] PH_STOP  = 2'd3;

  logic [1:0]    sync_q;
  logic          rx_s;
  logic [1:0]    phase_q;
  logic [CW-1:0] cnt_q;
  logic [2:0]    bit_idx_q;

  // Two-flop synchronizer, idles high
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rx_i};
    end
  end

  assign rx_s = sync_q[1];

  //////////////////////////////////////////////////////////////////////
  // Frame FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      phase_q   <= PH_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      valid_o   <= 1'b0;
    end else begin
      valid_o <= 1'b0;
      case (phase_q)
        PH_IDLE: begin
          cnt_q <= '0;
          if (!rx_s) phase_q <= PH_START;
        end
        PH_START: begin
          // Mid start bit, glitch returns to idle
          if (cnt_q == HALF_BIT) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            phase_q   <= rx_s ? PH_IDLE : PH_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        PH_DATA: begin
          if (cnt_q == FULL_BIT) begin
            cnt_q     <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) phase_q <= PH_STOP;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          // Bad stop bit drops the frame
          if (cnt_q == FULL_BIT) begin
            valid_o <= rx_s;
            phase_q <= PH_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  // LSB first, so each bit enters at the top
  always_ff @(posedge clk_i) begin
    if (phase_q == PH_DATA && cnt_q == FULL_BIT) begin
      byte_o <= {rx_s, byte_o[7:1]};
    end
  end

endmodule

// File: source/program_loader.sv
module program_loader #(
  parameter int RAM_DEPTH = 1024
) (
  input  logic                         clk_i,
  input  logic                         rst_n,
  input  logic [7:0]                   byte_i,
  input  logic                         byte_valid_i,
  output soc_mem_pkg::strb_t           we_o,
  output logic [$clog2(RAM_DEPTH)-1:0] addr_o,
  output soc_mem_pkg::data_t           wdata_o,
  output logic                         active_o,
  output logic                         sys_rst_n_o,
  output logic                         led_o
);

  localparam int RAM_AW = $clog2(RAM_DEPTH);

  soc_mem_pkg::loader_state_e state_q;
  logic [15:0]                count_q;
  logic [15:0]                word_idx_q;
  logic [1:0]                 byte_cnt_q;
  logic                       we_q;
  soc_mem_pkg::data_t         wbuf_q;

  //////////////////////////////////////////////////////////////////////
  // Load stream FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_q    <= soc_mem_pkg::IDLE;
      word_idx_q <= '0;
      byte_cnt_q <= '0;
      we_q       <= 1'b0;
    end else begin
      we_q <= 1'b0;
      case (state_q)
        soc_mem_pkg::IDLE: begin
          if (byte_valid_i && byte_i == soc_mem_pkg::OP_LOAD) begin
            state_q <= soc_mem_pkg::COUNT_LO;
          end
        end
        soc_mem_pkg::COUNT_LO: begin
          if (byte_valid_i) state_q <= soc_mem_pkg::COUNT_HI;
        end
        soc_mem_pkg::COUNT_HI: begin
          if (byte_valid_i) begin
            word_idx_q <= '0;
            byte_cnt_q <= '0;
            // Empty image finishes right away
            state_q <= ({byte_i, count_q[7:0]} == 16'd0) ? soc_mem_pkg::DONE
                                                          : soc_mem_pkg::DATA;
          end
        end
        soc_mem_pkg::DATA: begin
          if (byte_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 2'd1;
            if (byte_cnt_q == 2'd3) we_q <= 1'b1;
          end
          // Word goes out this cycle, step to the next
          if (we_q) begin
            word_idx_q <= word_idx_q + 16'd1;
            if (word_idx_q == count_q - 16'd1) state_q <= soc_mem_pkg::DONE;
          end
        end
        default: state_q <= soc_mem_pkg::IDLE;
      endcase
    end
  end

  // Count and word buffer, both little-endian
  always_ff @(posedge clk_i) begin
    if (byte_valid_i) begin
      if (state_q == soc_mem_pkg::COUNT_LO) count_q[7:0]  <= byte_i;
      if (state_q == soc_mem_pkg::COUNT_HI) count_q[15:8] <= byte_i;
      if (state_q == soc_mem_pkg::DATA)     wbuf_q        <= {byte_i, wbuf_q[31:8]};
    end
  end

  assign we_o    = {4{we_q}};
  assign addr_o  = word_idx_q[RAM_AW-1:0];
  assign wdata_o = wbuf_q;

  assign active_o    = (state_q == soc_mem_pkg::COUNT_LO) ||
                       (state_q == soc_mem_pkg::COUNT_HI) ||
                       (state_q == soc_mem_pkg::DATA);
  assign led_o       = active_o;
  assign sys_rst_n_o = !active_o;

  // Image must fit the RAM
  a_addr_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    we_q |-> (word_idx_q < RAM_DEPTH)
  );

endmodule

// File: source/iomem_fabric.sv
module iomem_fabric #(
  parameter int RAM_DEPTH = 1024,
  parameter int RAM_DELAY = 16
) (
  input  logic                         clk_i,
  input  logic                         rst_n,
  input  logic                         sys_rst_n_i,
  input  logic                         iomem_valid_i,
  output logic                         iomem_ready_o,
  input  soc_mem_pkg::strb_t           iomem_wstrb_i,
  input  soc_mem_pkg::addr_t           iomem_addr_i,
  output soc_mem_pkg::data_t           iomem_rdata_o,
  output soc_mem_pkg::strb_t           ram_we_o,
  output logic                         ram_re_o,
  output logic [$clog2(RAM_DEPTH)-1:0] ram_addr_o,
  input  soc_mem_pkg::data_t           ram_rdata_i
);

  localparam int RAM_AW = $clog2(RAM_DEPTH);

  logic                 ram_hit;
  logic                 tlo_hit;
  logic                 thi_hit;
  logic                 ram_done;
  logic                 req_seen_q;
  logic [RAM_DELAY-1:0] ready_sr_q;
  logic [63:0]          timer_q;

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  assign ram_hit = iomem_valid_i &&
                   ((iomem_addr_i & ~soc_mem_pkg::RAM_MASK_ADDR) == soc_mem_pkg::RAM_BASE_ADDR);
  assign tlo_hit = iomem_valid_i && (iomem_addr_i == soc_mem_pkg::TIMER_LO_ADDR);
  assign thi_hit = iomem_valid_i && (iomem_addr_i == soc_mem_pkg::TIMER_HI_ADDR);

  // Writes repeat each cycle valid is held, same data every time
  assign ram_we_o   = ram_hit ? iomem_wstrb_i : '0;
  assign ram_re_o   = ram_hit && (iomem_wstrb_i == '0);
  assign ram_addr_o = iomem_addr_i[RAM_AW+1:2];

  //////////////////////////////////////////////////////////////////////
  // RAM ready delay
  //////////////////////////////////////////////////////////////////////

  assign ram_done = ram_hit && iomem_ready_o;

  always_ff @(posedge clk_i) begin
    if (!sys_rst_n_i) begin
      req_seen_q <= 1'b0;
    end else begin
      req_seen_q <= ram_hit && !iomem_ready_o;
    end
  end

  // Chain empties on the handshake so the next request starts clean
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      ready_sr_q <= '0;
    end else if (ram_done) begin
      ready_sr_q <= '0;
    end else begin
      ready_sr_q <= {ready_sr_q[RAM_DELAY-2:0], req_seen_q};
    end
  end

  // Timer words answer in the same cycle
  assign iomem_ready_o = ready_sr_q[RAM_DELAY-1] || tlo_hit || thi_hit;

  //////////////////////////////////////////////////////////////////////
  // Cycle timer and read data
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!sys_rst_n_i) begin
      timer_q <= 64'd0;
    end else begin
      timer_q <= timer_q + 64'd1;
    end
  end

  assign iomem_rdata_o = tlo_hit ? timer_q[31:0]  :
                         thi_hit ? timer_q[63:32] : ram_rdata_i;

  // Bus master holds valid until the delayed ready comes back
  a_ready_needs_valid: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    iomem_ready_o |-> iomem_valid_i
  );

endmodule

// File: source/mem_subsystem.sv
module mem_subsystem #(
  parameter int RAM_DEPTH    = 1024,
  parameter int RAM_DELAY    = 16,
  parameter int CLKS_PER_BIT = 868
) (
  input  logic               clk_i,
  input  logic               rst_n,
  input  logic               iomem_valid_i,
  output logic               iomem_ready_o,
  input  soc_mem_pkg::strb_t iomem_wstrb_i,
  input  soc_mem_pkg::addr_t iomem_addr_i,
  input  soc_mem_pkg::data_t iomem_wdata_i,
  output soc_mem_pkg::data_t iomem_rdata_o,
  input  logic               program_rx_i,
  output logic               prog_mode_led_o,
  output logic               sys_rst_n_o
);

  localparam int RAM_AW = $clog2(RAM_DEPTH);

  // Fabric side of the RAM port
  soc_mem_pkg::strb_t fab_we;
  logic               fab_re;
  logic [RAM_AW-1:0]  fab_addr;

  // Loader side of the RAM port
  soc_mem_pkg::strb_t ld_we;
  logic [RAM_AW-1:0]  ld_addr;
  soc_mem_pkg::data_t ld_wdata;
  logic               prog_active;

  // Muxed RAM port
  soc_mem_pkg::strb_t ram_we;
  logic [RAM_AW-1:0]  ram_addr;
  soc_mem_pkg::data_t ram_wdata;
  soc_mem_pkg::data_t ram_rdata;

  logic [7:0] rx_byte;
  logic       rx_valid;
  logic       sys_rst_n;

  // System reset is held while a program is loading
  assign sys_rst_n = rst_n & sys_rst_n_o;

  // Loader owns the RAM write port during a load
  assign ram_we    = prog_active ? ld_we    : fab_we;
  assign ram_addr  = prog_active ? ld_addr  : fab_addr;
  assign ram_wdata = prog_active ? ld_wdata : iomem_wdata_i;

  iomem_fabric #(
    .RAM_DEPTH (RAM_DEPTH),
    .RAM_DELAY (RAM_DELAY)
  ) u_fabric (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .sys_rst_n_i   (sys_rst_n),
    .iomem_valid_i (iomem_valid_i),
    .iomem_ready_o (iomem_ready_o),
    .iomem_wstrb_i (iomem_wstrb_i),
    .iomem_addr_i  (iomem_addr_i),
    .iomem_rdata_o (iomem_rdata_o),
    .ram_we_o      (fab_we),
    .ram_re_o      (fab_re),
    .ram_addr_o    (fab_addr),
    .ram_rdata_i   (ram_rdata)
  );

  byte_ram #(
    .RAM_DEPTH (RAM_DEPTH)
  ) u_ram (
    .clk_i   (clk_i),
    .we_i    (ram_we),
    .re_i    (fab_re),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_rx (
    .clk_i   (clk_i),
    .rst_n   (rst_n),
    .rx_i    (program_rx_i),
    .byte_o  (rx_byte),
    .valid_o (rx_valid)
  );

  program_loader #(
    .RAM_DEPTH (RAM_DEPTH)
  ) u_loader (
    .clk_i        (clk_i),
    .rst_n        (rst_n),
    .byte_i       (rx_byte),
    .byte_valid_i (rx_valid),
    .we_o         (ld_we),
    .addr_o       (ld_addr),
    .wdata_o      (ld_wdata),
    .active_o     (prog_active),
    .sys_rst_n_o  (sys_rst_n_o),
    .led_o        (prog_mode_led_o)
  );

endmodule

// File: verification/mem_subsystem_vectors.svh
`ifndef MEM_SUBSYSTEM_VECTORS_SVH
`define MEM_SUBSYSTEM_VECTORS_SVH

  // Access kinds for the first column
  localparam logic [1:0] KIND_RAM_WR = 2'd0;
  localparam logic [1:0] KIND_RAM_RD = 2'd1;
  localparam logic [1:0] KIND_TMR_RD = 2'd2;

  typedef struct packed {
    logic [1:0]         kind;
    soc_mem_pkg::addr_t addr;
    soc_mem_pkg::strb_t strb;
    soc_mem_pkg::data_t wdata;
    soc_mem_pkg::data_t exp_rdata;
  } bus_vec_t;

  localparam int NUM_VEC = 13;

  // Columns are kind, address, strobes, write data, expected read data
  localparam bus_vec_t BUS_VEC [NUM_VEC] = '{
    '{KIND_RAM_WR, 32'h4000_0000, 4'b1111, 32'h1122_3344, 32'h0000_0000},
    '{KIND_RAM_WR, 32'h4000_0004, 4'b1111, 32'hdead_beef, 32'h0000_0000},
    '{KIND_RAM_RD, 32'h4000_0000, 4'b0000, 32'h0000_0000, 32'h1122_3344},
    '{KIND_RAM_RD, 32'h4000_0004, 4'b0000, 32'h0000_0000, 32'hdead_beef},
    // Partial strobes merge into the stored words
    '{KIND_RAM_WR, 32'h4000_0000, 4'b0001, 32'haaaa_aa55, 32'h0000_0000},
    '{KIND_RAM_WR, 32'h4000_0004, 4'b1100, 32'h0102_0304, 32'h0000_0000},
    '{KIND_RAM_RD, 32'h4000_0000, 4'b0000, 32'h0000_0000, 32'h1122_3355},
    '{KIND_RAM_RD, 32'h4000_0004, 4'b0000, 32'h0000_0000, 32'h0102_beef},
    '{KIND_RAM_WR, 32'h4000_0008, 4'b0110, 32'hffff_ffff, 32'h0000_0000},
    '{KIND_RAM_RD, 32'h4000_0008, 4'b0000, 32'h0000_0000, 32'h00ff_ff00},
    // Last word of the RAM
    '{KIND_RAM_WR, 32'h4000_0ffc, 4'b1111, 32'hcafe_f00d, 32'h0000_0000},
    '{KIND_RAM_RD, 32'h4000_0ffc, 4'b0000, 32'h0000_0000, 32'hcafe_f00d},
    '{KIND_TMR_RD, 32'h3000_0004, 4'b0000, 32'h0000_0000, 32'h0000_0000}
  };

  // Word 0 once the table has run
  localparam soc_mem_pkg::data_t WORD0_FINAL = 32'h1122_3355;

`endif

// File: verification/mem_subsystem_tb.sv
module mem_subsystem_tb;

  localparam int RAM_DEPTH    = 1024;
  localparam int RAM_DELAY    = 4;
  localparam int CLKS_PER_BIT = 8;
  localparam int CLK_PERIOD   = 4;
  localparam int LOAD_WORDS   = 6;
  localparam int UART_BYTES   = 1 + 1 + 2 + 4 * LOAD_WORDS;
  localparam int READY_LIMIT  = 64;
  localparam int TIMER_GAP    = 10;

  logic               clk_i = 1'b0;
  logic               rst_n;
  logic               iomem_valid_i;
  logic               iomem_ready_o;
  soc_mem_pkg::strb_t iomem_wstrb_i;
  soc_mem_pkg::addr_t iomem_addr_i;
  soc_mem_pkg::data_t iomem_wdata_i;
  soc_mem_pkg::data_t iomem_rdata_o;
  logic               program_rx_i;
  logic               prog_mode_led_o;
  logic               sys_rst_n_o;
  soc_mem_pkg::data_t load_words [LOAD_WORDS];
  time                sample_time;

  `include "mem_subsystem_vectors.svh"

  localparam longint WATCHDOG_TIME =
    (NUM_VEC * (RAM_DELAY + 4) + UART_BYTES * 12 * CLKS_PER_BIT + 200) * CLK_PERIOD;

  always #2 clk_i = ~clk_i;

  mem_subsystem #(
    .RAM_DEPTH    (RAM_DEPTH),
    .RAM_DELAY    (RAM_DELAY),
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_dut (
    .clk_i           (clk_i),
    .rst_n           (rst_n),
    .iomem_valid_i   (iomem_valid_i),
    .iomem_ready_o   (iomem_ready_o),
    .iomem_wstrb_i   (iomem_wstrb_i),
    .iomem_addr_i    (iomem_addr_i),
    .iomem_wdata_i   (iomem_wdata_i),
    .iomem_rdata_o   (iomem_rdata_o),
    .program_rx_i    (program_rx_i),
    .prog_mode_led_o (prog_mode_led_o),
    .sys_rst_n_o     (sys_rst_n_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input soc_mem_pkg::data_t got, input soc_mem_pkg::data_t exp,
                            input string msg);
    if (got !== exp) begin
      $display("FAIL @%0t: %s, got %h, expected %h", $time, msg, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      $display("FAIL @%0t: %s, got %b, expected %b", $time, msg, got, exp);
      abort_run();
    end
  endtask

  task automatic check_latency(input integer got, input integer exp, input string msg);
    if (got != exp) begin
      $display("FAIL @%0t: %s, got %0d cycles, expected %0d", $time, msg, got, exp);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus and UART drivers
  //////////////////////////////////////////////////////////////////////

  // Holds one request until ready and counts the cycles after valid
  task automatic bus_access(input soc_mem_pkg::addr_t addr, input soc_mem_pkg::strb_t strb,
                            input soc_mem_pkg::data_t wdata,
                            output soc_mem_pkg::data_t rdata, output integer lat);
    integer n;
    @(negedge clk_i);
    iomem_valid_i = 1'b1;
    iomem_addr_i  = addr;
    iomem_wstrb_i = strb;
    iomem_wdata_i = wdata;
    #1;
    n = 0;
    while (iomem_ready_o !== 1'b1) begin
      if (n == READY_LIMIT) begin
        $display("Bus request to %h never got ready", addr);
        abort_run();
      end
      @(negedge clk_i);
      #1;
      n++;
    end
    rdata       = iomem_rdata_o;
    sample_time = $time;
    lat         = n;
    @(posedge clk_i);
    @(negedge clk_i);
    iomem_valid_i = 1'b0;
    iomem_wstrb_i = '0;
    #1;
    check_bit(iomem_ready_o, 1'b0, "ready high for one cycle only");
  endtask

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    @(negedge clk_i);
    // Start bit, data LSB first, stop bit
    for (int k = 0; k < 10; k++) begin
      program_rx_i = frame[k];
      repeat (CLKS_PER_BIT) @(negedge clk_i);
    end
  endtask

  task automatic check_loading(input string msg);
    #1;
    check_bit(prog_mode_led_o, 1'b1, {"LED during load, ", msg});
    check_bit(sys_rst_n_o, 1'b0, {"system reset during load, ", msg});
  endtask

  task automatic wait_release(output time t_rel);
    int n;
    n = 0;
    while (sys_rst_n_o !== 1'b1) begin
      if (n == 4 * CLKS_PER_BIT) begin
        $display("Loader did not release the system reset after the image");
        abort_run();
      end
      @(negedge clk_i);
      #1;
      n++;
    end
    t_rel = $time;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    soc_mem_pkg::data_t rdata;
    soc_mem_pkg::data_t t_first;
    integer             lat;
    time                t_prev;
    time                t_rel;
    int                 elapsed;
    void'($urandom(32'h8b3a_07d7));
    rst_n         = 1'b0;
    iomem_valid_i = 1'b0;
    iomem_wstrb_i = '0;
    iomem_addr_i  = '0;
    iomem_wdata_i = '0;
    program_rx_i  = 1'b1;
    for (int w = 0; w < LOAD_WORDS; w++) begin
      load_words[w] = $urandom();
    end
    repeat (16) @(negedge clk_i);
    rst_n = 1'b1;
    #1;
    check_bit(iomem_ready_o, 1'b0, "ready after reset");
    check_bit(prog_mode_led_o, 1'b0, "LED after reset");
    check_bit(sys_rst_n_o, 1'b1, "system reset after reset");

    // Writes, byte merges, reads and the timer high word
    for (int i = 0; i < NUM_VEC; i++) begin
      bus_access(BUS_VEC[i].addr, BUS_VEC[i].strb, BUS_VEC[i].wdata, rdata, lat);
      check_latency(lat, (BUS_VEC[i].kind == KIND_TMR_RD) ? 0 : RAM_DELAY + 1,
                    $sformatf("entry %0d latency", i));
      if (BUS_VEC[i].kind != KIND_RAM_WR) begin
        check_data(rdata, BUS_VEC[i].exp_rdata, $sformatf("entry %0d read data", i));
      end
    end

    // Timer steps once per cycle
    bus_access(soc_mem_pkg::TIMER_LO_ADDR, '0, '0, t_first, lat);
    check_latency(lat, 0, "timer low latency");
    t_prev = sample_time;
    repeat (TIMER_GAP) @(negedge clk_i);
    bus_access(soc_mem_pkg::TIMER_LO_ADDR, '0, '0, rdata, lat);
    check_data(rdata - t_first, soc_mem_pkg::data_t'((sample_time - t_prev) / CLK_PERIOD),
               "timer step between reads");

    // Unknown first byte is ignored
    send_byte(8'h3c);
    repeat (4) @(negedge clk_i);
    #1;
    check_bit(prog_mode_led_o, 1'b0, "LED after bad opcode");
    check_bit(sys_rst_n_o, 1'b1, "system reset after bad opcode");
    bus_access(soc_mem_pkg::RAM_BASE_ADDR, '0, '0, rdata, lat);
    check_data(rdata, WORD0_FINAL, "word 0 after bad opcode");

    // Program image over the UART
    send_byte(soc_mem_pkg::OP_LOAD);
    check_loading("after opcode");
    send_byte(8'(LOAD_WORDS));
    check_loading("after count low");
    send_byte(8'(LOAD_WORDS >> 8));
    check_loading("after count high");
    for (int w = 0; w < LOAD_WORDS; w++) begin
      for (int b = 0; b < 4; b++) begin
        send_byte(load_words[w][8*b +: 8]);
        if (!(w == LOAD_WORDS - 1 && b == 3)) begin
          check_loading($sformatf("word %0d byte %0d", w, b));
        end
      end
    end
    wait_release(t_rel);
    check_bit(prog_mode_led_o, 1'b0, "LED after load");

    for (int w = 0; w < LOAD_WORDS; w++) begin
      bus_access(soc_mem_pkg::RAM_BASE_ADDR + 32'(4 * w), '0, '0, rdata, lat);
      check_latency(lat, RAM_DELAY + 1, $sformatf("loaded word %0d latency", w));
      check_data(rdata, load_words[w], $sformatf("loaded word %0d", w));
    end

    // Timer was held in reset through the load
    bus_access(soc_mem_pkg::TIMER_LO_ADDR, '0, '0, rdata, lat);
    elapsed = int'((sample_time - t_rel) / CLK_PERIOD);
    check_bit(rdata < 32'(elapsed + 3), 1'b1, "timer restarted at end of load");

    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog timeout, the tests did not finish in the expected time");
    abort_run();
  end

endmodule

// File: mem_subsystem.f
+incdir+verification
source/soc_mem_pkg.sv
source/byte_ram.sv
source/uart_rx.sv
source/program_loader.sv
source/iomem_fabric.sv
source/mem_subsystem.sv
verification/mem_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --assert -Wno-fatal --top-module mem_subsystem_tb \
  -f mem_subsystem.f -o mem_subsystem_sim > build.log 2>&1 \
  && ./obj_dir/mem_subsystem_sim > sim.log 2>&1
cat build.log sim.log 2>/dev/null
# A failure line or a missing pass line both mean the run failed
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
